// ==== sim.f ====
rtl/tsa_pkg.sv
rtl/ts_expect_gen.sv
rtl/ts_compare.sv
rtl/ts_match_counter.sv
rtl/tsa_top.sv
verification/tsa_tb.sv

// ==== verification/tsa_tb.sv ====
`timescale 1ns/1ps

module tsa_tb
    import tsa_pkg::*;
();

    localparam symbol_t    LINK_NUM     = 8'h01;
    localparam logic [5:0] RATE_SUPPORT = 6'h02;

    logic       clk;
    logic       rst;
    logic [7:0] ts_info;
    logic       ts_update;
    logic       ts_update_ack;
    logic [3:0] lane_num;
    logic       ts_sent_enough;
    logic       remote_ts_valid;
    ts_t        remote_ts;
    logic       tsa_p_a2c;
    logic       tsa_p2c;
    logic       tsa_c_ws2wa;
    logic       tsa_c_c2i;

    // reference model state
    logic [31:0] lcg_state;
    ts_kind_e    m_kind;
    ts_t         m_exp;     // set that counts with the link number already in symbol 1
    int          m_target;
    int          m_cnt;
    logic        m_match;
    logic [3:0]  m_flags;   // a2c, p2c, ws2wa, c2i

    tsa_top #(
        .LINK_NUM     (LINK_NUM),
        .RATE_SUPPORT (RATE_SUPPORT),
        .CNT_W        (16)
    ) i_dut (
        .clk             (clk),
        .rst             (rst),
        .ts_info         (ts_info),
        .ts_update       (ts_update),
        .ts_update_ack   (ts_update_ack),
        .lane_num        (lane_num),
        .ts_sent_enough  (ts_sent_enough),
        .remote_ts_valid (remote_ts_valid),
        .remote_ts       (remote_ts),
        .tsa_p_a2c       (tsa_p_a2c),
        .tsa_p2c         (tsa_p2c),
        .tsa_c_ws2wa     (tsa_c_ws2wa),
        .tsa_c_c2i       (tsa_c_c2i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        lcg_next  = {16'h0000, lcg_state[30:15]};
    endfunction

    function automatic symbol_t sym_at(input ts_t s, input int idx);
        sym_at = s[127 - 8*idx -: 8]; // symbol 0 is the top byte
    endfunction

    function automatic ts_t with_sym(input ts_t s, input int idx, input symbol_t v);
        ts_t r;
        r = s;
        r[127 - 8*idx -: 8] = v;
        with_sym = r;
    endfunction

    function automatic logic [7:0] info_of(input ts_kind_e k);
        case (k)
            poll_active:  info_of = {ST_POLL, SUB_POLL_ACTIVE};
            poll_cfg:     info_of = {ST_POLL, SUB_POLL_CFG};
            cfg_lw_start: info_of = {ST_CFG, SUB_CFG_LW_START};
            cfg_complete: info_of = {ST_CFG, SUB_CFG_COMPLETE};
            default:      info_of = 8'h37; // state code 3 is not decoded
        endcase
    endfunction

    function automatic logic [3:0] flag_of(input ts_kind_e k);
        case (k)
            poll_active:  flag_of = 4'b1000;
            poll_cfg:     flag_of = 4'b0100;
            cfg_lw_start: flag_of = 4'b0010;
            cfg_complete: flag_of = 4'b0001;
            default:      flag_of = 4'b0000;
        endcase
    endfunction

    function automatic int target_of(input ts_kind_e k);
        case (k)
            poll_active, poll_cfg: target_of = int'(RX_NUM_POLL);
            cfg_lw_start:          target_of = int'(RX_NUM_LW_START);
            cfg_complete:          target_of = int'(RX_NUM_CFG_C2I);
            default:               target_of = 0;
        endcase
    endfunction

    // the one ordered set that the partner should send in substate k
    function automatic ts_t build_expected(input ts_kind_e k, input logic [3:0] lane);
        ts_t     s;
        symbol_t id;
        id = (k == poll_cfg || k == cfg_complete) ? TS2_ID : TS1_ID;
        s  = '0;
        s  = with_sym(s, 0, SYM_COM);
        s  = with_sym(s, 1, (k == cfg_lw_start || k == cfg_complete) ? LINK_NUM : SYM_PAD);
        s  = with_sym(s, 2, (k == cfg_complete) ? {4'h0, lane} : SYM_PAD);
        s  = with_sym(s, 3, SYM_NFTS);
        s  = with_sym(s, 4, {2'b00, RATE_SUPPORT});
        s  = with_sym(s, 5, SYM_ZERO);
        for (int i = 6; i < 16; i++)
            s = with_sym(s, i, id);
        build_expected = s;
    endfunction

    // exact copy half the time, else id swap, wrong link or lane, or one random symbol
    function automatic ts_t make_set(input ts_t exp);
        ts_t         s;
        logic [31:0] r;
        int          idx;
        symbol_t     b;
        s = exp;
        r = lcg_next();
        if (!r[0])
            return s;
        if (r[2:1] == 2'd0) begin
            for (int i = 6; i < 16; i++)
                s = with_sym(s, i, (sym_at(s, i) == TS1_ID) ? TS2_ID : TS1_ID);
            return s;
        end
        idx = (r[2:1] == 2'd1) ? 1 + int'(r[3]) : int'(r[6:3]);
        r   = lcg_next();
        b   = r[7:0];
        if (b == sym_at(s, idx))
            b = b ^ 8'h80; // make sure it really differs
        make_set = with_sym(s, idx, b);
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else
            report_failure($sformatf("Error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic check_flags(input logic [3:0] exp);
        check_bit("tsa_p_a2c", tsa_p_a2c, exp[3]);
        check_bit("tsa_p2c", tsa_p2c, exp[2]);
        check_bit("tsa_c_ws2wa", tsa_c_ws2wa, exp[1]);
        check_bit("tsa_c_c2i", tsa_c_c2i, exp[0]);
    endtask

    // advance the model on the inputs the DUT sampled at this edge
    task automatic run_cycle();
        logic [3:0] nxt_flags;
        @(posedge clk);
        #1;
        nxt_flags = m_flags;
        if (m_flags == 4'b0000 && m_cnt >= m_target &&
            (ts_sent_enough || m_kind == cfg_lw_start))
            nxt_flags = flag_of(m_kind);
        if (m_match && m_flags == 4'b0000)
            m_cnt++;
        m_match = remote_ts_valid && m_kind != none && remote_ts == m_exp;
        m_flags = nxt_flags;
        check_flags(m_flags);
    endtask

    // four-phase request with a 2 cycle limit on each ack edge
    task automatic do_update(input logic [7:0] info, input logic [3:0] lane);
        int waited;
        ts_info        = info;
        lane_num       = lane;
        ts_sent_enough = 1'b0;
        ts_update      = 1'b1;
        waited         = 0;
        while (!ts_update_ack) begin
            if (waited == 2)
                report_failure("ts_update_ack did not rise within 2 cycles of the request");
            @(posedge clk);
            #1;
            waited++;
        end
        ts_update = 1'b0;
        @(posedge clk);
        #1;
        check_flags(4'b0000); // load clears the old flag here
        waited = 1;
        while (ts_update_ack) begin
            if (waited == 2)
                report_failure("ts_update_ack did not fall within 2 cycles of the request drop");
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic run_phase(input ts_kind_e k);
        logic [3:0]  lane;
        logic [31:0] r;
        int          n_sets;
        int          sent_at;
        int          sent;
        int          cyc;
        r    = lcg_next();
        lane = r[3:0];
        do_update(info_of(k), lane);
        m_kind   = k;
        m_exp    = build_expected(k, lane);
        m_target = target_of(k);
        m_cnt    = 0;
        m_match  = 1'b0;
        m_flags  = 4'b0000;
        n_sets   = 40 + int'(lcg_next() % 21);
        sent_at  = int'(lcg_next() % 40);
        sent     = 0;
        cyc      = 0;
        while (sent < n_sets) begin
            if (cyc == sent_at)
                ts_sent_enough = 1'b1;
            r = lcg_next();
            remote_ts_valid = (r[1:0] != 2'd0); // idle cycle now and then
            remote_ts       = remote_ts_valid ? make_set(m_exp) : '0;
            if (remote_ts_valid)
                sent++;
            run_cycle();
            cyc++;
        end
        remote_ts_valid = 1'b0;
        repeat (4) run_cycle(); // let the pipeline drain
        assert (m_flags == flag_of(k)) else
            report_failure($sformatf("no transition flag for substate %s", k.name()));
    endtask

    initial begin
        ts_kind_e order[5];
        order = '{poll_active, poll_cfg, cfg_lw_start, cfg_complete, none};
        lcg_state       = 32'd60;
        rst             = 1'b1;
        ts_info         = 8'h00;
        ts_update       = 1'b0;
        lane_num        = 4'h0;
        ts_sent_enough  = 1'b0;
        remote_ts_valid = 1'b0;
        remote_ts       = '0;
        m_kind          = none;
        m_exp           = '0;
        m_target        = 0;
        m_cnt           = 0;
        m_match         = 1'b0;
        m_flags         = 4'b0000;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_bit("ts_update_ack", ts_update_ack, 1'b0);
        check_flags(4'b0000);
        for (int round = 0; round < 2; round++)
            for (int i = 0; i < 5; i++)
                run_phase(order[i]);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== rtl/tsa_top.sv ====
`timescale 1ns/1ps

module tsa_top
    import tsa_pkg::*;
#(
    parameter symbol_t    LINK_NUM     = 8'h01,
    parameter logic [5:0] RATE_SUPPORT = 6'h02,
    parameter int         CNT_W        = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] ts_info,
    input  logic       ts_update,
    output logic       ts_update_ack,
    input  logic [3:0] lane_num,
    input  logic       ts_sent_enough,
    input  logic       remote_ts_valid,
    input  ts_t        remote_ts,
    output logic       tsa_p_a2c,
    output logic       tsa_p2c,
    output logic       tsa_c_ws2wa,
    output logic       tsa_c_c2i
);

    logic        load;
    ts_kind_e    kind;
    ts_t         exp_ts;
    ts_t         exp_mask;
    logic [15:0] target;
    logic        ts_match;

    // handshake and expectation
    ts_expect_gen #(
        .LINK_NUM     (LINK_NUM),
        .RATE_SUPPORT (RATE_SUPPORT)
    ) i_expect (
        .clk           (clk),
        .rst           (rst),
        .ts_info       (ts_info),
        .ts_update     (ts_update),
        .lane_num      (lane_num),
        .ts_update_ack (ts_update_ack),
        .load          (load),
        .kind          (kind),
        .exp_ts        (exp_ts),
        .exp_mask      (exp_mask),
        .target        (target)
    );

    ts_compare #(
        .LINK_NUM (LINK_NUM)
    ) i_compare (
        .clk             (clk),
        .rst             (rst),
        .load            (load),
        .kind            (kind),
        .exp_ts          (exp_ts),
        .exp_mask        (exp_mask),
        .remote_ts_valid (remote_ts_valid),
        .remote_ts       (remote_ts),
        .ts_match        (ts_match)
    );

    ts_match_counter #(
        .CNT_W (CNT_W)
    ) i_counter (
        .clk            (clk),
        .rst            (rst),
        .load           (load),
        .kind           (kind),
        .target         (target),
        .ts_match       (ts_match),
        .ts_sent_enough (ts_sent_enough),
        .tsa_p_a2c      (tsa_p_a2c),
        .tsa_p2c        (tsa_p2c),
        .tsa_c_ws2wa    (tsa_c_ws2wa),
        .tsa_c_c2i      (tsa_c_c2i)
    );

endmodule

// ==== rtl/ts_match_counter.sv ====
`timescale 1ns/1ps

module ts_match_counter
    import tsa_pkg::*;
#(
    parameter int CNT_W = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        load,
    input  ts_kind_e    kind,
    input  logic [15:0] target,
    input  logic        ts_match,
    input  logic        ts_sent_enough,
    output logic        tsa_p_a2c,
    output logic        tsa_p2c,
    output logic        tsa_c_ws2wa,
    output logic        tsa_c_c2i
);

    // compare width covers both the counter and the 16 bit target
    localparam int CMP_W = (CNT_W > 16) ? CNT_W : 16;

    logic [CNT_W-1:0] cnt;
    logic             reached;
    logic             flag_set;
    logic             flag_ok;

    assign reached  = CMP_W'(cnt) >= CMP_W'(target);
    assign flag_set = tsa_p_a2c | tsa_p2c | tsa_c_ws2wa | tsa_c_c2i;

    // linkwidth.start moves on without waiting for our own tx side
    assign flag_ok = reached && (ts_sent_enough || kind == cfg_lw_start);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= '0;
        end else if (ts_match && !flag_set && cnt != '1) begin
            cnt <= cnt + 1'b1; // saturates and holds once a flag is up
        end
    end

    // sticky until the next update
    always_ff @(posedge clk) begin
        if (rst || load) begin
            tsa_p_a2c   <= 1'b0;
            tsa_p2c     <= 1'b0;
            tsa_c_ws2wa <= 1'b0;
            tsa_c_c2i   <= 1'b0;
        end else if (!flag_set && flag_ok) begin
            case (kind)
                poll_active:  tsa_p_a2c   <= 1'b1;
                poll_cfg:     tsa_p2c     <= 1'b1;
                cfg_lw_start: tsa_c_ws2wa <= 1'b1;
                cfg_complete: tsa_c_c2i   <= 1'b1;
                default: ; // kind none raises nothing
            endcase
        end
    end

endmodule

// ==== rtl/ts_compare.sv ====
`timescale 1ns/1ps

module ts_compare
    import tsa_pkg::*;
#(
    parameter symbol_t LINK_NUM = 8'h01
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  ts_kind_e kind,
    input  ts_t      exp_ts,
    input  ts_t      exp_mask,
    input  logic     remote_ts_valid,
    input  ts_t      remote_ts,
    output logic     ts_match
);

    ts_t  remote_masked;
    ts_t  exp_masked;
    logic set_eq;
    logic link_ok;
    logic armed;

    assign remote_masked = remote_ts & exp_mask;
    assign exp_masked    = exp_ts & exp_mask;
    assign set_eq        = (remote_masked == exp_masked);

    // linkwidth.start masks symbol 1 out of the set compare
    // and wants our own link number there instead
    assign link_ok = (kind != cfg_lw_start) || (ts_sym(remote_ts, 1) == LINK_NUM);

    // nothing counts before the first update or while loading a new one
    assign armed = (kind != none) && !load;

    always_ff @(posedge clk) begin
        if (rst) begin
            ts_match <= 1'b0;
        end else begin
            ts_match <= remote_ts_valid && armed && set_eq && link_ok;
        end
    end

endmodule

// ==== rtl/ts_expect_gen.sv ====
`timescale 1ns/1ps

module ts_expect_gen
    import tsa_pkg::*;
#(
    parameter symbol_t     LINK_NUM     = 8'h01,
    parameter logic [5:0]  RATE_SUPPORT = 6'h02
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  ts_info,   // state [7:4], substate [3:0]
    input  logic        ts_update,
    input  logic [3:0]  lane_num,
    output logic        ts_update_ack,
    output logic        load,
    output ts_kind_e    kind,
    output ts_t         exp_ts,
    output ts_t         exp_mask,
    output logic [15:0] target
);

    logic        accept;
    ts_kind_e    kind_nxt;
    ts_t         exp_nxt;
    ts_t         mask_nxt;
    logic [15:0] target_nxt;
    symbol_t     id_sym;

    // new request only once the previous ack has dropped
    assign accept = ts_update && !ts_update_ack;

    always_comb begin
        kind_nxt = none;
        case (ts_info[7:4])
            ST_POLL: begin
                if (ts_info[3:0] == SUB_POLL_ACTIVE)
                    kind_nxt = poll_active;
                else if (ts_info[3:0] == SUB_POLL_CFG)
                    kind_nxt = poll_cfg;
            end
            ST_CFG: begin
                if (ts_info[3:0] == SUB_CFG_LW_START)
                    kind_nxt = cfg_lw_start;
                else if (ts_info[3:0] == SUB_CFG_COMPLETE)
                    kind_nxt = cfg_complete;
            end
            default: kind_nxt = none;
        endcase
    end

    // expected set, mask and count target for the decoded substate
    always_comb begin
        id_sym = (kind_nxt == poll_active || kind_nxt == cfg_lw_start) ? TS1_ID : TS2_ID;
        exp_nxt  = '0;
        mask_nxt = '1;
        exp_nxt  = ts_put(exp_nxt, 0, SYM_COM);
        exp_nxt  = ts_put(exp_nxt, 1, SYM_PAD);
        exp_nxt  = ts_put(exp_nxt, 2, SYM_PAD);
        exp_nxt  = ts_put(exp_nxt, 3, SYM_NFTS);
        exp_nxt  = ts_put(exp_nxt, 4, {2'b00, RATE_SUPPORT});
        exp_nxt  = ts_put(exp_nxt, 5, SYM_ZERO);
        for (int i = 6; i < 16; i++)
            exp_nxt = ts_put(exp_nxt, i, id_sym);

        case (kind_nxt)
            cfg_lw_start: begin
                exp_nxt  = ts_put(exp_nxt, 1, SYM_ZERO);   // link checked in compare
                mask_nxt = ts_put(mask_nxt, 1, SYM_ZERO);
            end
            cfg_complete: begin
                exp_nxt = ts_put(exp_nxt, 1, LINK_NUM);
                exp_nxt = ts_put(exp_nxt, 2, {4'h0, lane_num});
            end
            default: ;
        endcase

        case (kind_nxt)
            poll_active, poll_cfg: target_nxt = RX_NUM_POLL;
            cfg_lw_start:          target_nxt = RX_NUM_LW_START;
            cfg_complete:          target_nxt = RX_NUM_CFG_C2I;
            default:               target_nxt = '0;
        endcase
    end

    // four-phase responder
    always_ff @(posedge clk) begin
        if (rst) begin
            ts_update_ack <= 1'b0;
            load          <= 1'b0;
            kind          <= none;
            target        <= '0;
        end else begin
            load <= accept; // one cycle pulse
            if (accept) begin
                ts_update_ack <= 1'b1;
                kind          <= kind_nxt;
                target        <= target_nxt;
            end else if (!ts_update) begin
                ts_update_ack <= 1'b0; // request gone
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exp_ts   <= exp_nxt;
            exp_mask <= mask_nxt;
        end
    end

endmodule

// ==== rtl/tsa_pkg.sv ====
package tsa_pkg;

    // line symbol and 16-symbol ordered set with symbol 0 in the top byte
    typedef logic [7:0]   symbol_t;
    typedef logic [127:0] ts_t;

    // substate the analyzer is currently checking for
    typedef enum logic [2:0] {
        none,
        poll_active,
        poll_cfg,
        cfg_lw_start,
        cfg_complete
    } ts_kind_e;

    // ts_info upper nibble
    localparam logic [3:0] ST_POLL = 4'd1;
    localparam logic [3:0] ST_CFG  = 4'd2;

    // polling substate codes in the ts_info lower nibble
    localparam logic [3:0] SUB_POLL_ACTIVE = 4'd0;
    localparam logic [3:0] SUB_POLL_CFG    = 4'd1;

    // configuration substate codes in the ts_info lower nibble
    localparam logic [3:0] SUB_CFG_LW_START = 4'd0;
    localparam logic [3:0] SUB_CFG_COMPLETE = 4'd4;

    localparam symbol_t SYM_COM  = 8'hBC; // comma in symbol 0
    localparam symbol_t SYM_PAD  = 8'hF7; // link / lane pad
    localparam symbol_t SYM_NFTS = 8'hFF; // symbol 3
    localparam symbol_t SYM_ZERO = 8'h00; // symbol 5
    localparam symbol_t TS1_ID   = 8'h4A;
    localparam symbol_t TS2_ID   = 8'h45;

    // number of matching sets needed per substate
    localparam logic [15:0] RX_NUM_POLL     = 16'd8;
    localparam logic [15:0] RX_NUM_LW_START = 16'd2;
    localparam logic [15:0] RX_NUM_CFG_C2I  = 16'd8;

    // pick symbol idx out of an ordered set
    function automatic symbol_t ts_sym(input ts_t ts, input int idx);
        ts_sym = ts[127 - 8*idx -: 8];
    endfunction

    // write one symbol into a set
    function automatic ts_t ts_put(input ts_t ts, input int idx, input symbol_t sym);
        ts_t res;
        res = ts;
        res[127 - 8*idx -: 8] = sym;
        ts_put = res;
    endfunction

endpackage
